// File: Bender.yml
package:
  name: c2c_link

sources:
  - include_dirs:
      - src
    files:
      - src/c2c_pkg.sv
      - src/notice_counter.sv
      - src/master_control.sv
      - src/slave_control.sv
      - src/seg7_decoder.sv
      - src/c2c_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_c2c_top.sv

// File: dv/tb_c2c_top.sv
`timescale 1ns/100ps
`include "c2c_cfg.svh"

module tb_c2c_top;

    // bound for every wait loop, in clock cycles.
    localparam int TIMEOUT = 4 * (`C2C_NOTICE_CYCLES + 10);

    logic                   clk;
    logic                   rst_n;
    logic                   send;
    logic [`C2C_DATA_W-1:0] value;
    logic                   busy;
    logic                   notice;
    logic [`C2C_SEG_W-1:0]  seg;

    // expected active-low patterns, bit 0 is segment a.
    logic [`C2C_SEG_W-1:0]  seg_table [0:7];
    logic [31:0]            rng;
    int                     errors;
    int                     errors_at_start;
    int                     tests_run;
    int                     tests_failed;
    bit                     notice_seen;

    c2c_top dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .send   (send),
        .value  (value),
        .busy   (busy),
        .notice (notice),
        .seg    (seg)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // called right after a falling edge; strobes send for one cycle.
    task automatic issue_send(input logic [`C2C_DATA_W-1:0] digit);
        send  = 1'b1;
        value = digit;
        @(negedge clk);
        send  = 1'b0;
    endtask

    // waits until busy reaches level, noting any notice pulse on the way.
    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        notice_seen = notice;
        while (busy !== level && n < TIMEOUT) begin
            @(negedge clk);
            if (notice) notice_seen = 1'b1;
            n++;
        end
        if (busy !== level) begin
            $display("timeout: busy never went %0s during %0s", level ? "high" : "low", what);
            errors++;
        end
    endtask

    task automatic transfer(input logic [`C2C_DATA_W-1:0] digit, input string what);
        issue_send(digit);
        wait_busy(1'b1, what);
        wait_busy(1'b0, what);
    endtask

    task automatic check_seg(input logic [`C2C_DATA_W-1:0] digit, input string what);
        if (seg !== seg_table[digit]) begin
            $display("[ERROR] %0t: %0s seg is %b, expected %b for digit %0d",
                     $time, what, seg, seg_table[digit], digit);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %0s: failed, %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %0s: ok", name);
        end
        errors_at_start = errors;
    endtask

    ////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////

    task automatic check_reset_state();
        if (busy !== 1'b0 || notice !== 1'b0) begin
            $display("[ERROR] %0t: after reset busy=%b notice=%b", $time, busy, notice);
            errors++;
        end
        check_seg(0, "reset");
        finish_test("reset_state");
    endtask

    task automatic single_transfer();
        transfer(5, "single transfer");
        if (!notice_seen) begin
            $display("[ERROR] %0t: notice never went high during the transfer", $time);
            errors++;
        end
        repeat (2) @(negedge clk);
        check_seg(5, "single transfer");
        if (notice !== 1'b0) begin
            $display("[ERROR] %0t: notice still high after the transfer", $time);
            errors++;
        end
        finish_test("single_transfer");
    endtask

    task automatic all_digits();
        for (int d = 0; d < 8; d++) begin
            transfer(d, "all digits");
            repeat (2) @(negedge clk);
            check_seg(d, "all digits");
        end
        finish_test("all_digits");
    endtask

    task automatic ignore_send_while_busy();
        issue_send(3);
        wait_busy(1'b1, "send while busy");
        // second strobe lands in the middle of the notice interval.
        repeat (2) @(negedge clk);
        issue_send(6);
        wait_busy(1'b0, "send while busy");
        repeat (2) @(negedge clk);
        check_seg(3, "send while busy");
        // no second transfer may start from the dropped strobe.
        for (int n = 0; n < `C2C_NOTICE_CYCLES + 10; n++) begin
            @(negedge clk);
            if (busy !== 1'b0) begin
                $display("[ERROR] %0t: busy rose again after an ignored send", $time);
                errors++;
                break;
            end
        end
        check_seg(3, "send while busy");
        finish_test("send_while_busy");
    endtask

    task automatic random_back_to_back();
        logic [`C2C_DATA_W-1:0] prev;
        logic [`C2C_DATA_W-1:0] cur;
        rng = xorshift32(rng);
        cur = rng[`C2C_DATA_W-1:0];
        transfer(cur, "random back to back");
        for (int i = 1; i < 20; i++) begin
            prev = cur;
            rng  = xorshift32(rng);
            cur  = rng[`C2C_DATA_W-1:0];
            // next send goes out at once; the old digit stays shown meanwhile.
            issue_send(cur);
            @(negedge clk);
            check_seg(prev, "random back to back");
            wait_busy(1'b1, "random back to back");
            wait_busy(1'b0, "random back to back");
        end
        repeat (2) @(negedge clk);
        check_seg(cur, "random back to back");
        finish_test("random_back_to_back");
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        send            = 1'b0;
        value           = '0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        notice_seen     = 1'b0;
        rng             = 32'd90;
        seg_table[0] = 7'b1000000;
        seg_table[1] = 7'b1111001;
        seg_table[2] = 7'b0100100;
        seg_table[3] = 7'b0110000;
        seg_table[4] = 7'b0011001;
        seg_table[5] = 7'b0010010;
        seg_table[6] = 7'b0000010;
        seg_table[7] = 7'b1111000;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        single_transfer();
        all_digits();
        ignore_send_while_busy();
        random_back_to_back();
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src/c2c_cfg.svh
`ifndef C2C_CFG_SVH
`define C2C_CFG_SVH

//////////////////////////////////////////////////
// link configuration
//////////////////////////////////////////////////

// width of the value carried over the link.
// the display decoder covers digits 0 to 7 only.
`define C2C_DATA_W 3

// length of the slave notice interval in clock cycles.
// kept short so a transfer finishes quickly in simulation.
// a board build would stretch this toward one second.
`define C2C_NOTICE_CYCLES 8

// seven-segment digit width, one bit per segment a to g.
`define C2C_SEG_W 7

`endif

// File: src/c2c_pkg.sv
`include "c2c_cfg.svh"

package c2c_pkg;

    //////////////////////////////////////////////////
    // master to slave direction
    //////////////////////////////////////////////////

    // request is a level, valid is a one-cycle strobe.
    // data is held stable by the master while valid is high.
    typedef struct packed {
        logic                   request;
        logic                   valid;
        logic [`C2C_DATA_W-1:0] data;
    } c2c_link_t;

    //////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////

    // master side of the transfer.
    // code 2'b11 is unused and falls back to idle.
    typedef enum logic [1:0] {
        m_idle      = 2'b00,
        m_wait_ack  = 2'b01,
        m_send_data = 2'b10
    } master_state_e;

    // slave side of the transfer.
    // code 2'b10 is unused and falls back to wait_rqst.
    typedef enum logic [1:0] {
        s_wait_rqst        = 2'b00,
        s_wait_to_send_ack = 2'b01,
        s_wait_data        = 2'b11
    } slave_state_e;

endpackage

// File: src/c2c_top.sv
`timescale 1ns/100ps
`include "c2c_cfg.svh"

module c2c_top
    import c2c_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   send,
    input  logic [`C2C_DATA_W-1:0] value,
    output logic                   busy,
    output logic                   notice,
    output logic [`C2C_SEG_W-1:0]  seg
);

    //////////////////////////////////////////////////
    // link between the two controllers
    //////////////////////////////////////////////////

    // request, valid and data from master to slave.
    c2c_link_t              link;
    // ack pulse back from slave to master.
    logic                   ack;
    // received value toward the display.
    logic [`C2C_DATA_W-1:0] data;

    master_control u_master (
        .clk   (clk),
        .rst_n (rst_n),
        .send  (send),
        .value (value),
        .ack   (ack),
        .link  (link),
        .busy  (busy)
    );

    slave_control u_slave (
        .clk    (clk),
        .rst_n  (rst_n),
        .link   (link),
        .ack    (ack),
        .notice (notice),
        .data   (data)
    );

    // display of the last received value.
    seg7_decoder u_seg (
        .clk   (clk),
        .rst_n (rst_n),
        .digit (data),
        .seg   (seg)
    );

endmodule

// File: src/master_control.sv
`timescale 1ns/100ps
`include "c2c_cfg.svh"

module master_control
    import c2c_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   send,
    input  logic [`C2C_DATA_W-1:0] value,
    input  logic                   ack,
    output c2c_link_t              link,
    output logic                   busy
);

    master_state_e          state;
    master_state_e          next_state;
    logic                   req_q;
    logic                   next_req;
    logic                   valid_q;
    logic                   next_valid;
    logic [`C2C_DATA_W-1:0] data_q;
    logic                   capture;

    // a send strobe only counts while idle.
    assign capture = (state == m_idle) && send;

    //////////////////////////////////////////////////
    // next-state logic
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        next_req   = req_q;
        // valid is a strobe, low unless set below.
        next_valid = 1'b0;
        case (state)
            m_idle: begin
                if (send) begin
                    next_state = m_wait_ack;
                    next_req   = 1'b1;
                end
            end
            m_wait_ack: begin
                // drop request and present data right after ack.
                if (ack) begin
                    next_state = m_send_data;
                    next_req   = 1'b0;
                    next_valid = 1'b1;
                end
            end
            m_send_data: begin
                // valid is high in this state for one cycle.
                next_state = m_idle;
            end
            default: begin
                next_state = m_idle;
                next_req   = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= m_idle;
            req_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            state   <= next_state;
            req_q   <= next_req;
            valid_q <= next_valid;
        end
    end

    // captured value, held until the next accepted send.
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= value;
        end
    end

    // drive the link toward the slave.
    assign link.request = req_q;
    assign link.valid   = valid_q;
    assign link.data    = data_q;

    // busy from the cycle after send until back in idle.
    assign busy = (state != m_idle);

endmodule

// File: src/notice_counter.sv
`timescale 1ns/100ps
`include "c2c_cfg.svh"

module notice_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    // interval length and the count width it needs.
    localparam int unsigned CYCLES = `C2C_NOTICE_CYCLES;
    localparam int unsigned CNT_W  = (CYCLES > 1) ? $clog2(CYCLES) : 1;

    // last count value of the interval.
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CYCLES - 1);

    logic [CNT_W-1:0] count;
    logic             at_last;

    assign at_last = (count == LAST);

    // count while start is held, clear whenever it drops.
    // the count parks on the last value until start falls.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!start) begin
            count <= '0;
        end else if (!at_last) begin
            count <= count + 1'b1;
        end
    end

    // done once start has been high for CYCLES cycles.
    // qualified by start so a stale count never flags done.
    assign done = start && at_last;

endmodule

// File: src/seg7_decoder.sv
`timescale 1ns/100ps
`include "c2c_cfg.svh"

module seg7_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`C2C_DATA_W-1:0] digit,
    output logic [`C2C_SEG_W-1:0]  seg
);

    // segments are active low, bit 0 is a and bit 6 is g.
    localparam logic [`C2C_SEG_W-1:0] SEG_ZERO  = 7'b1000000;

    logic [`C2C_SEG_W-1:0] seg_next;

    // digit to pattern lookup.
    always_comb begin
        case (digit)
            0:       seg_next = SEG_ZERO;
            1:       seg_next = 7'b1111001;
            2:       seg_next = 7'b0100100;
            3:       seg_next = 7'b0110000;
            4:       seg_next = 7'b0011001;
            5:       seg_next = 7'b0010010;
            6:       seg_next = 7'b0000010;
            // digit 7.
            default: seg_next = 7'b1111000;
        endcase
    end

    // one register stage, so seg trails digit by a cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg <= SEG_ZERO;
        end else begin
            seg <= seg_next;
        end
    end

endmodule

// File: src/slave_control.sv
`timescale 1ns/100ps
`include "c2c_cfg.svh"

module slave_control
    import c2c_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  c2c_link_t              link,
    output logic                   ack,
    output logic                   notice,
    output logic [`C2C_DATA_W-1:0] data
);

    slave_state_e           state;
    slave_state_e           next_state;
    logic                   start;
    logic                   next_start;
    logic                   next_ack;
    logic                   next_notice;
    logic [`C2C_DATA_W-1:0] next_data;
    logic                   done;

    // notice interval timer, runs while start is held.
    notice_counter u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .done  (done)
    );

    //////////////////////////////////////////////////
    // next-state logic
    //////////////////////////////////////////////////

    always_comb begin
        next_state  = state;
        next_start  = start;
        next_ack    = ack;
        next_notice = notice;
        next_data   = data;
        case (state)
            s_wait_rqst: begin
                // request is only looked at here.
                next_state  = link.request ? s_wait_to_send_ack : s_wait_rqst;
                next_start  = link.request;
                next_ack    = 1'b0;
                next_notice = 1'b0;
            end
            s_wait_to_send_ack: begin
                // hold notice through the interval, then one ack pulse.
                next_state  = done ? s_wait_data : s_wait_to_send_ack;
                next_start  = !done;
                next_ack    = done;
                next_notice = !done;
            end
            s_wait_data: begin
                next_state  = link.valid ? s_wait_rqst : s_wait_data;
                next_start  = 1'b0;
                next_ack    = 1'b0;
                next_notice = 1'b0;
                // latch on valid, zero while still waiting.
                next_data   = link.valid ? link.data : '0;
            end
            default: begin
                // unused code 2'b10, recover to a clean wait.
                next_state  = s_wait_rqst;
                next_start  = 1'b0;
                next_ack    = 1'b0;
                next_notice = 1'b0;
                next_data   = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // registered outputs
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= s_wait_rqst;
            start  <= 1'b0;
            ack    <= 1'b0;
            notice <= 1'b0;
            data   <= '0;
        end else begin
            state  <= next_state;
            start  <= next_start;
            ack    <= next_ack;
            notice <= next_notice;
            data   <= next_data;
        end
    end

endmodule

// File: vlog.f
+incdir+src
src/c2c_pkg.sv
src/notice_counter.sv
src/master_control.sv
src/slave_control.sv
src/seg7_decoder.sv
src/c2c_top.sv
dv/tb_c2c_top.sv
